// File: fetch_pkg.sv
/* Fetch path sizes and the parcel record. FIFO_DEPTH is kept a power of two */
package fetch_pkg;

    localparam int XLEN       = 32;
    localparam int PARCEL_W   = 16;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000; // first fetch word

    typedef struct packed {
        logic [PARCEL_W-1:0] bits;
        logic [XLEN-1:0]     pc;   // address of this parcel
    } parcel_t;

endpackage

// File: rv32c_pkg.sv
/* RV32 Zca/Zcf/Zcd expansion helpers. Reserved and HINT-free illegal forms return UNIMP.
   RV32 only, so shift amounts with bit 5 set count as reserved */
package rv32c_pkg;

    localparam logic [31:0] UNIMP  = 32'hc000_1073; // csrrw x0, cycle, x0
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    localparam logic [6:0] OP_LOAD     = 7'b0000011;
    localparam logic [6:0] OP_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OP_IMM      = 7'b0010011;
    localparam logic [6:0] OP_STORE    = 7'b0100011;
    localparam logic [6:0] OP_STORE_FP = 7'b0100111;
    localparam logic [6:0] OP_OP       = 7'b0110011;
    localparam logic [6:0] OP_LUI      = 7'b0110111;
    localparam logic [6:0] OP_BRANCH   = 7'b1100011;
    localparam logic [6:0] OP_JALR     = 7'b1100111;
    localparam logic [6:0] OP_JAL      = 7'b1101111;

    // 3-bit compressed register field maps onto x8..x15
    function automatic logic [4:0] creg(logic [2:0] r);
        return {2'b01, r};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // c.addi4spn
    function automatic logic [31:0] decompress_ciw(logic [15:0] c);
        logic [11:0] imm;
        imm = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
        if (imm == '0) return UNIMP; // nzuimm of zero is reserved
        return enc_i(imm, 5'd2, 3'b000, creg(c[4:2]), OP_IMM);
    endfunction

    // c.fld / c.lw / c.flw, bit 13 picks the fp opcode
    function automatic logic [31:0] decompress_cl(logic [15:0] c);
        logic [11:0] imm;
        imm = c[14] ? {5'b0, c[5], c[12:10], c[6], 2'b00} : {4'b0, c[6:5], c[12:10], 3'b000};
        return enc_i(imm, creg(c[9:7]), c[14] ? 3'b010 : 3'b011, creg(c[4:2]),
                     c[13] ? OP_LOAD_FP : OP_LOAD);
    endfunction

    // c.fsd / c.sw / c.fsw
    function automatic logic [31:0] decompress_cs(logic [15:0] c);
        logic [11:0] imm;
        imm = c[14] ? {5'b0, c[5], c[12:10], c[6], 2'b00} : {4'b0, c[6:5], c[12:10], 3'b000};
        return enc_s(imm, creg(c[4:2]), creg(c[9:7]), c[14] ? 3'b010 : 3'b011,
                     c[13] ? OP_STORE_FP : OP_STORE);
    endfunction

    // addi, li, lui, addi16sp, srli, srai, slli
    function automatic logic [31:0] decompress_ci_arith(logic [15:0] c);
        logic [11:0] imm6;
        logic [11:0] imm16;
        logic [4:0]  rd;
        imm6  = {{6{c[12]}}, c[12], c[6:2]};
        imm16 = {{2{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000}; // scaled by 16
        rd    = c[11:7];
        case ({c[15:13], c[1:0]})
            5'b000_01: return enc_i(imm6, rd, 3'b000, rd, OP_IMM);   // c.addi, c.nop
            5'b010_01: return enc_i(imm6, 5'd0, 3'b000, rd, OP_IMM); // c.li
            5'b011_01: begin
                if ({c[12], c[6:2]} == 6'd0) return UNIMP;
                if (rd == 5'd2) return enc_i(imm16, 5'd2, 3'b000, 5'd2, OP_IMM);
                return {{14{c[12]}}, c[12], c[6:2], rd, OP_LUI};
            end
            5'b100_01: begin
                if (c[12]) return UNIMP;
                // bit 10 set turns srli into srai
                return enc_i({1'b0, c[10], 5'b0, c[6:2]}, creg(c[9:7]), 3'b101,
                             creg(c[9:7]), OP_IMM);
            end
            5'b000_10: begin
                if (c[12]) return UNIMP;
                return enc_i({7'b0, c[6:2]}, rd, 3'b001, rd, OP_IMM); // c.slli
            end
            default: return UNIMP;
        endcase
    endfunction

    // sp-relative loads
    function automatic logic [31:0] decompress_ci_load(logic [15:0] c);
        logic [11:0] imm_w;
        imm_w = {4'b0, c[3:2], c[12], c[6:4], 2'b00};
        case (c[14:13])
            2'b01: return enc_i({3'b0, c[4:2], c[12], c[6:5], 3'b000}, 5'd2, 3'b011, c[11:7],
                                OP_LOAD_FP);
            2'b10: begin
                if (c[11:7] == 5'd0) return UNIMP; // c.lwsp into x0 is reserved
                return enc_i(imm_w, 5'd2, 3'b010, c[11:7], OP_LOAD);
            end
            2'b11: return enc_i(imm_w, 5'd2, 3'b010, c[11:7], OP_LOAD_FP);
            default: return UNIMP;
        endcase
    endfunction

    // sub / xor / or / and
    function automatic logic [31:0] decompress_ca(logic [15:0] c);
        logic [2:0] f3;
        if (c[12]) return UNIMP; // word ops only exist on RV64
        f3 = {c[6] | c[5], c[6], c[6] & c[5]}; // 000 100 110 111
        return enc_r(c[6:5] == 2'b00 ? 7'b0100000 : 7'b0000000, creg(c[4:2]), creg(c[9:7]), f3,
                     creg(c[9:7]), OP_OP);
    endfunction

    // c.andi plus c.beqz / c.bnez
    function automatic logic [31:0] decompress_cb(logic [15:0] c);
        logic [12:0] b;
        b = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        if (c[15:13] == 3'b100)
            return enc_i({{6{c[12]}}, c[12], c[6:2]}, creg(c[9:7]), 3'b111, creg(c[9:7]), OP_IMM);
        return {b[12], b[10:5], 5'd0, creg(c[9:7]), 2'b00, c[13], b[4:1], b[11], OP_BRANCH};
    endfunction

    // c.jal links x1, c.j links nothing
    function automatic logic [31:0] decompress_cj(logic [15:0] c);
        logic [20:0] j;
        j = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        return {j[20], j[10:1], j[11], j[19:12], c[15] ? 5'd0 : 5'd1, OP_JAL};
    endfunction

    // jr, mv, ebreak, jalr, add
    function automatic logic [31:0] decompress_cr(logic [15:0] c);
        logic [4:0] rs1;
        logic [4:0] rs2;
        rs1 = c[11:7];
        rs2 = c[6:2];
        if (!c[12]) begin
            if (rs2 != 5'd0) return enc_r(7'b0, rs2, 5'd0, 3'b000, rs1, OP_OP);
            if (rs1 == 5'd0) return UNIMP;
            return enc_i(12'd0, rs1, 3'b000, 5'd0, OP_JALR);
        end
        if (rs2 != 5'd0) return enc_r(7'b0, rs2, rs1, 3'b000, rs1, OP_OP);
        if (rs1 == 5'd0) return EBREAK;
        return enc_i(12'd0, rs1, 3'b000, 5'd1, OP_JALR);
    endfunction

    // sp-relative stores
    function automatic logic [31:0] decompress_css(logic [15:0] c);
        logic [11:0] imm_w;
        imm_w = {4'b0, c[8:7], c[12:9], 2'b00};
        case (c[14:13])
            2'b01: return enc_s({3'b0, c[9:7], c[12:10], 3'b000}, c[6:2], 5'd2, 3'b011,
                                OP_STORE_FP);
            2'b10: return enc_s(imm_w, c[6:2], 5'd2, 3'b010, OP_STORE);
            2'b11: return enc_s(imm_w, c[6:2], 5'd2, 3'b010, OP_STORE_FP);
            default: return UNIMP;
        endcase
    endfunction

endpackage

// File: parcel_if.sv
/* One parcel per transfer, moved when valid and ready are both high */
`timescale 1ns/1ps

interface parcel_if;

    logic               valid;
    logic               ready;
    fetch_pkg::parcel_t parcel;

    modport producer (output valid, output parcel, input ready);
    modport consumer (input valid, input parcel, output ready);

endinterface

// File: parcel_splitter.sv
/* Holds one aligned fetch word and hands out its halves, low half first.
   Takes a new word only once both halves have left */
`timescale 1ns/1ps

module parcel_splitter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       fetch_valid,
    output logic                       fetch_ready,
    input  logic [fetch_pkg::XLEN-1:0] fetch_word,
    parcel_if.producer                 out
);

    logic [fetch_pkg::XLEN-1:0] word_q;
    logic                       full_q;  // word held
    logic                       half_q;  // high half next
    logic [fetch_pkg::XLEN-1:0] pc_q;    // pc of the parcel on offer

    assign fetch_ready      = !full_q;
    assign out.valid        = full_q;
    assign out.parcel.bits  = half_q ? word_q[31:16] : word_q[15:0];
    assign out.parcel.pc    = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
            half_q <= 1'b0;
            pc_q   <= fetch_pkg::RESET_PC;
        end else if (fetch_valid && fetch_ready) begin
            full_q <= 1'b1;
            half_q <= 1'b0;
        end else if (out.valid && out.ready) begin
            pc_q <= pc_q + 32'd2;
            if (half_q) begin
                full_q <= 1'b0; // both halves gone
                half_q <= 1'b0;
            end else begin
                half_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) word_q <= fetch_word;
    end

endmodule

// File: parcel_fifo.sv
/* Circular parcel queue, FIFO_DEPTH entries. Push and pop may share a cycle,
   a pushed parcel shows at the output one cycle later */
`timescale 1ns/1ps

module parcel_fifo (
    input  logic       clk,
    input  logic       rst_n,
    parcel_if.consumer in,
    parcel_if.producer out
);

    fetch_pkg::parcel_t              mem [fetch_pkg::FIFO_DEPTH];
    logic [fetch_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [fetch_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [fetch_pkg::FIFO_CNT_W-1:0] count;
    logic                             push;
    logic                             pop;

    assign in.ready   = count != fetch_pkg::FIFO_CNT_W'(fetch_pkg::FIFO_DEPTH);
    assign out.valid  = count != '0;
    assign out.parcel = mem[rd_ptr];
    assign push       = in.valid && in.ready;
    assign pop        = out.valid && out.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // none, or one in and one out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in.parcel;
    end

endmodule

// File: decompressor.sv
/* Combinational RV32C expansion. Zcb, Zcmp and Zcmt encodings are not expanded,
   their enables only shape which of the standard slots stay live */
`timescale 1ns/1ps

module decompressor #(
    parameter bit ZCA  = 1,
    parameter bit ZCF  = 1,
    parameter bit ZCD  = 1,
    parameter bit ZCB  = 0,
    parameter bit ZCMP = 0,
    parameter bit ZCMT = 0
) (
    input  logic [15:0] compressed,
    output logic [31:0] decompressed
);

    localparam bit C_ON = ZCA || ZCB || ZCMP || ZCMT; // every subset pulls in zca
    localparam bit F_ON = C_ON && ZCF;
    localparam bit D_ON = C_ON && ZCD && !ZCMP && !ZCMT; // push/pop and table jump reuse fld slots

    always_comb begin
        decompressed = rv32c_pkg::UNIMP; // also covers full-size parcels
        if (C_ON) begin
            case ({compressed[15:13], compressed[1:0]})
                5'b000_00: decompressed = rv32c_pkg::decompress_ciw(compressed); // zero nzuimm
                5'b010_00: decompressed = rv32c_pkg::decompress_cl(compressed);
                5'b001_00: if (D_ON) decompressed = rv32c_pkg::decompress_cl(compressed);
                5'b011_00: if (F_ON) decompressed = rv32c_pkg::decompress_cl(compressed);
                5'b110_00: decompressed = rv32c_pkg::decompress_cs(compressed);
                5'b101_00: if (D_ON) decompressed = rv32c_pkg::decompress_cs(compressed);
                5'b111_00: if (F_ON) decompressed = rv32c_pkg::decompress_cs(compressed);
                5'b000_01, 5'b010_01, 5'b011_01, 5'b000_10:
                    decompressed = rv32c_pkg::decompress_ci_arith(compressed);
                5'b100_01: begin
                    // shifts, andi and register ops share this slot
                    if (compressed[11:10] == 2'b11)
                        decompressed = rv32c_pkg::decompress_ca(compressed);
                    else if (compressed[11:10] == 2'b10)
                        decompressed = rv32c_pkg::decompress_cb(compressed);
                    else
                        decompressed = rv32c_pkg::decompress_ci_arith(compressed);
                end
                5'b001_01, 5'b101_01: decompressed = rv32c_pkg::decompress_cj(compressed);
                5'b110_01, 5'b111_01: decompressed = rv32c_pkg::decompress_cb(compressed);
                5'b010_10: decompressed = rv32c_pkg::decompress_ci_load(compressed);
                5'b001_10: if (D_ON) decompressed = rv32c_pkg::decompress_ci_load(compressed);
                5'b011_10: if (F_ON) decompressed = rv32c_pkg::decompress_ci_load(compressed);
                5'b100_10: decompressed = rv32c_pkg::decompress_cr(compressed);
                5'b110_10: decompressed = rv32c_pkg::decompress_css(compressed);
                5'b101_10: if (D_ON) decompressed = rv32c_pkg::decompress_css(compressed);
                5'b111_10: if (F_ON) decompressed = rv32c_pkg::decompress_css(compressed);
                default:   decompressed = rv32c_pkg::UNIMP; // 100_00 reserved
            endcase
        end
    end

endmodule

// File: insn_assembler.sv
/* Rebuilds instructions from parcels, 16 and 32 bit only (no 48-bit forms).
   A lower half is kept until its upper half arrives, even across fetch words */
`timescale 1ns/1ps

module insn_assembler (
    input  logic                       clk,
    input  logic                       rst_n,
    parcel_if.consumer                 in,
    output logic                       insn_valid,
    input  logic                       insn_ready,
    output logic [fetch_pkg::XLEN-1:0] insn,
    output logic [fetch_pkg::XLEN-1:0] insn_pc,
    output logic                       insn_compressed
);

    logic                           out_valid_q;
    logic [fetch_pkg::XLEN-1:0]     insn_q;
    logic [fetch_pkg::XLEN-1:0]     pc_q;
    logic                           cmp_q;
    logic                           lo_valid_q;  // lower half waiting
    logic [fetch_pkg::PARCEL_W-1:0] lo_bits_q;
    logic [fetch_pkg::XLEN-1:0]     lo_pc_q;
    logic [fetch_pkg::XLEN-1:0]     expanded;
    logic                           pop;
    logic                           is_full;

    decompressor u_decompressor (
        .compressed   (in.parcel.bits),
        .decompressed (expanded)
    );

    assign in.ready = !out_valid_q || insn_ready; // output slot free next edge
    assign pop      = in.valid && in.ready;
    assign is_full  = in.parcel.bits[1:0] == 2'b11;

    assign insn_valid      = out_valid_q;
    assign insn            = insn_q;
    assign insn_pc         = pc_q;
    assign insn_compressed = cmp_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
            lo_valid_q  <= 1'b0;
        end else begin
            if (insn_valid && insn_ready) out_valid_q <= 1'b0;
            if (pop) begin
                if (lo_valid_q) begin
                    out_valid_q <= 1'b1; // upper half completes the word
                    lo_valid_q  <= 1'b0;
                end else if (is_full) begin
                    lo_valid_q <= 1'b1;
                end else begin
                    out_valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            if (lo_valid_q) begin
                insn_q <= {in.parcel.bits, lo_bits_q};
                pc_q   <= lo_pc_q;                 // pc of the lower half
                cmp_q  <= 1'b0;
            end else if (is_full) begin
                lo_bits_q <= in.parcel.bits;
                lo_pc_q   <= in.parcel.pc;
            end else begin
                insn_q <= expanded;
                pc_q   <= in.parcel.pc;
                cmp_q  <= 1'b1;
            end
        end
    end

endmodule

// File: rvc_expander_top.sv
/* Fetch words in, expanded instructions out, both as valid/ready streams.
   Latency varies with parcel mix and back-pressure */
`timescale 1ns/1ps

module rvc_expander_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       fetch_valid,
    output logic                       fetch_ready,
    input  logic [fetch_pkg::XLEN-1:0] fetch_word,
    output logic                       insn_valid,
    input  logic                       insn_ready,
    output logic [fetch_pkg::XLEN-1:0] insn,
    output logic [fetch_pkg::XLEN-1:0] insn_pc,
    output logic                       insn_compressed
);

    parcel_if split_to_buf ();
    parcel_if buf_to_asm ();

    parcel_splitter u_splitter (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_word  (fetch_word),
        .out         (split_to_buf.producer)
    );

    parcel_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (split_to_buf.consumer),
        .out   (buf_to_asm.producer)
    );

    insn_assembler u_assembler (
        .clk             (clk),
        .rst_n           (rst_n),
        .in              (buf_to_asm.consumer),
        .insn_valid      (insn_valid),
        .insn_ready      (insn_ready),
        .insn            (insn),
        .insn_pc         (insn_pc),
        .insn_compressed (insn_compressed)
    );

endmodule

// File: tb_rvc_expander.sv
/* Self-checking testbench for rvc_expander_top. Reads rvc_expander_tests.txt from the
   working directory, so run it from the project root. Stalls and gaps use a fixed seed */
`timescale 1ns/1ps

module tb_rvc_expander;

    localparam int MEM_DEPTH    = 64;  // header, words and expected entries together
    localparam int DRAIN_CYCLES = 20;  // idle time that would expose extra outputs

    logic        clk = 1'b0;
    logic        rst_n;
    logic        fetch_valid;
    logic        fetch_ready;
    logic [31:0] fetch_word;
    logic        insn_valid;
    logic        insn_ready;
    logic [31:0] insn;
    logic [31:0] insn_pc;
    logic        insn_compressed;

    logic [67:0] tests_mem [MEM_DEPTH];   // raw image of the data file
    logic [31:0] fetch_words [MEM_DEPTH];
    logic [64:0] expected [MEM_DEPTH];    // {insn, pc, compressed}

    int     num_words    = 0;
    int     num_insns    = 0;
    int     max_cycles   = 0;
    int     word_idx     = 0;  // fetch words accepted so far
    int     out_count    = 0;  // instructions taken so far
    int     cycles       = 0;
    int     check_errors = 0;
    int     run_errors   = 0;
    integer seed;

    rvc_expander_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_valid     (fetch_valid),
        .fetch_ready     (fetch_ready),
        .fetch_word      (fetch_word),
        .insn_valid      (insn_valid),
        .insn_ready      (insn_ready),
        .insn            (insn),
        .insn_pc         (insn_pc),
        .insn_compressed (insn_compressed)
    );

    always #2 clk = ~clk; // 4 ns period

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            check_errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // handshakes sampled at the rising edge, ahead of the register updates
    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (word_idx == 0) begin  // idle state until the first word goes in
                check_value("fetch_ready before first word", 32'(fetch_ready), 32'd1);
                check_value("insn_valid before first word", 32'(insn_valid), 32'd0);
            end
            if (fetch_valid && fetch_ready) word_idx++;
            if (insn_valid && insn_ready) begin
                if (out_count < num_insns) begin
                    check_value($sformatf("insn %0d", out_count), insn,
                                expected[out_count][64:33]);
                    check_value($sformatf("insn_pc %0d", out_count), insn_pc,
                                expected[out_count][32:1]);
                    check_value($sformatf("insn_compressed %0d", out_count),
                                32'(insn_compressed), 32'(expected[out_count][0]));
                end else begin
                    check_errors++;
                    $display("Extra instruction %h at pc %h after all expected ones",
                             insn, insn_pc);
                end
                out_count++;
            end
        end
    end

    initial begin
        logic [67:0] raw;
        int          offer_idx;
        offer_idx   = -1;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_word  = '0;
        insn_ready  = 1'b0;
        seed        = 32'hc62e5130;

        $readmemh("rvc_expander_tests.txt", tests_mem);
        num_words = int'(tests_mem[0][31:0]);
        num_insns = int'(tests_mem[1][31:0]);
        if (num_words == 0 || num_insns == 0 || 2 + num_words + num_insns > MEM_DEPTH) begin
            run_errors++;
            $display("Data file holds unusable counts: %0d words, %0d instructions",
                     num_words, num_insns);
            num_words = 0;
            num_insns = 0;
        end
        for (int i = 0; i < num_words; i++) fetch_words[i] = tests_mem[2 + i][31:0];
        for (int i = 0; i < num_insns; i++) begin
            raw         = tests_mem[2 + num_words + i];
            expected[i] = {raw[67:36], raw[35:4], raw[0]}; // flag sits in the last digit
        end
        max_cycles = 20 * num_insns + 100;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        while (out_count < num_insns && cycles < max_cycles) begin
            @(negedge clk);
            // a new word only once the offered one has been taken
            if (!fetch_valid || word_idx > offer_idx) begin
                if (word_idx < num_words && ($random(seed) % 4) != 0) begin
                    offer_idx   = word_idx;
                    fetch_valid = 1'b1;
                    fetch_word  = fetch_words[word_idx];
                end else begin
                    fetch_valid = 1'b0;  // gap
                end
            end
            insn_ready = ($random(seed) % 3) != 0; // stall about a third of cycles
        end

        @(negedge clk);
        fetch_valid = 1'b0;
        insn_ready  = 1'b1;
        if (out_count < num_insns) begin
            run_errors++;
            $display("Timeout after %0d cycles with %0d of %0d instructions received",
                     cycles, out_count, num_insns);
        end else begin
            repeat (DRAIN_CYCLES) @(negedge clk);
        end
        if (word_idx != num_words) begin
            run_errors++;
            $display("Only %0d of %0d fetch words were accepted", word_idx, num_words);
        end

        $display("Instructions seen: %0d of %0d, check errors: %0d, run errors: %0d",
                 out_count, num_insns, check_errors, run_errors);
        if (check_errors == 0 && run_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rvc_expander_tests.txt
// counts first (hex): fetch words, then expected instructions
// then fetch words, then expected entries as insn(8) pc(8) compressed(1) hex digits
a
11
41440040 // c.addi4spn, c.lw
52fdc504 // c.sw, c.li
c4018c05 // c.sub, c.beqz
852ea801 // c.j, c.mv
4092c206 // c.swsp, c.lwsp
00100093 // aligned addi
12345137 // aligned lui
82930000 // zero parcel, lower half of addi x5
800007f2 // upper half of addi x5, reserved quadrant 0 code
00014002 // c.lwsp into x0, c.nop
00410413800000001 // addi x8, sp, 4
00452483800000021 // lw x9, 4(x10)
00952423800000041 // sw x9, 8(x10)
fff00293800000061 // addi x5, x0, -1
40940433800000081 // sub x8, x8, x9
000404638000000a1 // beq x8, x0, 8
0100006f8000000c1 // jal x0, 16
00b005338000000e1 // add x10, x0, x11
00112223800000101 // sw x1, 4(sp)
00412083800000121 // lw x1, 4(sp)
00100093800000140 // full size, aligned
12345137800000180 // full size, aligned
c00010738000001c1 // zero parcel gives unimp
07f282938000001e0 // straddles two fetch words
c0001073800000221 // reserved gives unimp
c0001073800000241 // reserved gives unimp
00000013800000261 // c.nop

// File: rvc_expander_top.f
fetch_pkg.sv
rv32c_pkg.sv
parcel_if.sv
parcel_splitter.sv
parcel_fifo.sv
decompressor.sv
insn_assembler.sv
rvc_expander_top.sv
tb_rvc_expander.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

verilator --binary --top-module tb_rvc_expander -f rvc_expander_top.f -o sim_rvc_expander
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_rvc_expander)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
